// File: logic/spi_link_pkg.sv
package spi_link_pkg;

    localparam int num_slaves          = 2;
    localparam bit sclk_cpol           = 1'b0;
    localparam int extra_write_toggles = 6;
    localparam int extra_read_toggles  = 4;
    localparam int read_data_toggles   = 18;
    localparam int queue_depth         = 4;

    // two toggles per frame bit.
    localparam int command_toggles     = 32;
    localparam int write_frame_toggles = command_toggles + extra_write_toggles;
    localparam int read_frame_toggles  = command_toggles + extra_read_toggles
                                         + read_data_toggles;

    typedef logic [6:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [15:0] spi_frame_t; // address byte on top, bit 15 is the read flag.
    typedef logic [0:0]  slave_sel_t;
    typedef logic [5:0]  toggle_count_t;

    typedef enum logic [1:0] {
        idle,
        active,
        done
    } master_state_t;

endpackage

// File: logic/spi_master.sv
`timescale 1ns/1ps

module spi_master
    import spi_link_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  frame_start,
    input  slave_sel_t            frame_slave,
    input  spi_frame_t            frame_data,
    input  logic                  frame_read,
    output logic                  frame_done,
    output reg_data_t             frame_rdata,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso,
    output logic [num_slaves-1:0] ss_n
);

    master_state_t state;
    toggle_count_t toggle_count;
    toggle_count_t toggle_limit;
    logic          read_q;
    spi_frame_t    tx_shift;
    reg_data_t     rx_shift;
    logic          sclk_off_idle;
    logic          frame_end;
    logic          reply_phase;

    assign sclk_off_idle = (sclk != sclk_cpol); // next toggle is the falling edge.
    assign frame_end     = (state == active) && (toggle_count == toggle_limit);

    // rising edges after the idle toggles belong to the reply.
    assign reply_phase = read_q
                         && (toggle_count > toggle_count_t'(command_toggles + extra_read_toggles));

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state        <= idle;
            toggle_count <= '0;
            sclk         <= sclk_cpol;
            ss_n         <= '1;
            mosi         <= 1'b0;
            frame_done   <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                idle: begin
                    if (frame_start) begin
                        ss_n[frame_slave] <= 1'b0;
                        mosi              <= frame_data[8]; // address lsb is set up first.
                        toggle_count      <= '0;
                        state             <= active;
                    end
                end
                active: begin
                    if (frame_end) begin
                        ss_n       <= '1;
                        sclk       <= sclk_cpol;
                        mosi       <= 1'b0;
                        frame_done <= 1'b1;
                        state      <= done;
                    end else begin
                        sclk         <= ~sclk;
                        toggle_count <= toggle_count + 1'b1;
                        if (sclk_off_idle) begin
                            mosi <= tx_shift[1]; // zeros follow once the frame is out.
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == idle) && frame_start) begin
            tx_shift     <= {frame_data[7:0], frame_data[15:8]};
            rx_shift     <= '0;
            read_q       <= frame_read;
            toggle_limit <= frame_read ? toggle_count_t'(read_frame_toggles)
                                       : toggle_count_t'(write_frame_toggles);
        end else if ((state == active) && !frame_end && sclk_off_idle) begin
            tx_shift <= tx_shift >> 1;
            if (reply_phase) begin
                rx_shift <= {miso, rx_shift[7:1]}; // the last eight samples stay.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_end) begin
            frame_rdata <= rx_shift;
        end
    end

    a_one_select: assert property (
        @(posedge clk) disable iff (!reset_n)
        $onehot0(~ss_n)
    );

    // the sequencer alone keeps frames from overlapping.
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!reset_n)
        frame_start |-> (state == idle)
    );

endmodule

// File: logic/reg_access_sequencer.sv
`timescale 1ns/1ps

module reg_access_sequencer
    import spi_link_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       req_valid,
    input  slave_sel_t req_slave,
    input  reg_addr_t  req_addr,
    input  logic       req_write,
    input  reg_data_t  req_wdata,
    output logic       frame_start,
    output slave_sel_t frame_slave,
    output spi_frame_t frame_data,
    output logic       frame_read,
    input  logic       frame_done,
    input  reg_data_t  frame_rdata,
    output logic       rsp_valid,
    output slave_sel_t rsp_slave,
    output reg_addr_t  rsp_addr,
    output reg_data_t  rsp_rdata,
    output logic       overflow
);

    typedef logic [$clog2(queue_depth)-1:0] queue_ptr_t;

    slave_sel_t q_slave [queue_depth];
    reg_addr_t  q_addr  [queue_depth];
    logic       q_write [queue_depth];
    reg_data_t  q_wdata [queue_depth];

    queue_ptr_t                   wr_ptr;
    queue_ptr_t                   rd_ptr;
    logic [$clog2(queue_depth):0] count;
    logic                         in_flight;
    slave_sel_t                   inf_slave;
    reg_addr_t                    inf_addr;
    logic                         inf_write;
    logic                         full;
    logic                         push;
    logic                         pop;

    function automatic queue_ptr_t ptr_next(input queue_ptr_t ptr);
        return (ptr == queue_ptr_t'(queue_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == queue_depth);
    assign push = req_valid && !full;
    assign pop  = !in_flight && (count != 0); // one frame at a time.

    assign frame_start = pop;
    assign frame_slave = q_slave[rd_ptr];
    assign frame_read  = !q_write[rd_ptr];
    assign frame_data  = {frame_read, q_addr[rd_ptr], q_wdata[rd_ptr]};

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_flight <= 1'b0;
            rsp_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (req_valid && full) begin
                overflow <= 1'b1; // the request itself is lost.
            end
            if (pop) begin
                in_flight <= 1'b1;
            end else if (frame_done) begin
                in_flight <= 1'b0;
            end
            rsp_valid <= frame_done;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_slave[wr_ptr] <= req_slave;
            q_addr[wr_ptr]  <= req_addr;
            q_write[wr_ptr] <= req_write;
            q_wdata[wr_ptr] <= req_wdata;
        end
        if (pop) begin
            inf_slave <= frame_slave;
            inf_addr  <= q_addr[rd_ptr];
            inf_write <= q_write[rd_ptr];
        end
        if (frame_done) begin
            rsp_slave <= inf_slave;
            rsp_addr  <= inf_addr;
            rsp_rdata <= inf_write ? reg_data_t'(0) : frame_rdata;
        end
    end

    a_done_in_flight: assert property (
        @(posedge clk) disable iff (!reset_n)
        frame_done |-> in_flight
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (!reset_n)
        count <= queue_depth
    );

endmodule

// File: logic/spi_sensor_link.sv
`timescale 1ns/1ps

module spi_sensor_link
    import spi_link_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  req_valid,
    input  slave_sel_t            req_slave,
    input  reg_addr_t             req_addr,
    input  logic                  req_write,
    input  reg_data_t             req_wdata,
    output logic                  rsp_valid,
    output slave_sel_t            rsp_slave,
    output reg_addr_t             rsp_addr,
    output reg_data_t             rsp_rdata,
    output logic                  overflow,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso,
    output logic [num_slaves-1:0] ss_n
);

    logic       frame_start;
    slave_sel_t frame_slave;
    spi_frame_t frame_data;
    logic       frame_read;
    logic       frame_done;
    reg_data_t  frame_rdata;

    reg_access_sequencer reg_access_sequencer_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .req_valid   (req_valid),
        .req_slave   (req_slave),
        .req_addr    (req_addr),
        .req_write   (req_write),
        .req_wdata   (req_wdata),
        .frame_start (frame_start),
        .frame_slave (frame_slave),
        .frame_data  (frame_data),
        .frame_read  (frame_read),
        .frame_done  (frame_done),
        .frame_rdata (frame_rdata),
        .rsp_valid   (rsp_valid),
        .rsp_slave   (rsp_slave),
        .rsp_addr    (rsp_addr),
        .rsp_rdata   (rsp_rdata),
        .overflow    (overflow)
    );

    spi_master spi_master_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .frame_slave (frame_slave),
        .frame_data  (frame_data),
        .frame_read  (frame_read),
        .frame_done  (frame_done),
        .frame_rdata (frame_rdata),
        .sclk        (sclk),
        .mosi        (mosi),
        .miso        (miso),
        .ss_n        (ss_n)
    );

endmodule

// File: dv/spi_slave_model.sv
`timescale 1ns/1ps

module spi_slave_model
    import spi_link_pkg::*;
(
    input  logic                  sclk,
    input  logic                  mosi,
    output logic                  miso,
    input  logic [num_slaves-1:0] ss_n
);

    reg_data_t   regs [num_slaves][128];
    logic [15:0] cmd; // address byte in the low half, data byte in the high half.
    int          rise_count;
    logic        no_select;
    logic        sel;

    assign no_select = &ss_n;
    assign sel       = ~ss_n[1]; // a low ss_n[1] picks slave 1.

    initial begin
        miso       = 1'b0;
        cmd        = '0;
        rise_count = 0;
        for (int a = 0; a < 128; a++) begin
            regs[0][a] = reg_data_t'(a) ^ 8'h5a;
            regs[1][a] = reg_data_t'(a) + 8'h30;
        end
    end

    // the frame is received lsb first, one bit per rising edge.
    always @(posedge sclk or posedge no_select) begin
        if (no_select) begin
            rise_count <= 0;
        end else begin
            if (rise_count < 16) begin
                cmd[rise_count] <= mosi;
            end
            if ((rise_count == 16) && !cmd[7]) begin
                regs[sel][cmd[6:0]] <= cmd[15:8]; // the whole write frame is in.
            end
            rise_count <= rise_count + 1;
        end
    end

    // Reply bits are set up on the falling edge before the rising edge that takes them,
    // so the last eight rising edges of a read frame see bits 0 to 7.
    always @(negedge sclk or posedge no_select) begin
        if (no_select) begin
            miso <= 1'b0;
        end else if (cmd[7] && (rise_count >= read_frame_toggles / 2 - 8)
                     && (rise_count < read_frame_toggles / 2)) begin
            miso <= regs[sel][cmd[6:0]][rise_count - (read_frame_toggles / 2 - 8)];
        end else begin
            miso <= 1'b0;
        end
    end

endmodule

// File: dv/tb_spi_sensor_link.sv
`timescale 1ns/1ps

module tb_spi_sensor_link
    import spi_link_pkg::*;
();

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  req_valid;
    slave_sel_t            req_slave;
    reg_addr_t             req_addr;
    logic                  req_write;
    reg_data_t             req_wdata;
    logic                  rsp_valid;
    slave_sel_t            rsp_slave;
    reg_addr_t             rsp_addr;
    reg_data_t             rsp_rdata;
    logic                  overflow;
    logic                  sclk;
    logic                  mosi;
    logic                  miso;
    logic [num_slaves-1:0] ss_n;

    reg_data_t   shadow [num_slaves][128];
    logic [15:0] exp_q [$]; // {slave, addr, rdata}.
    logic [15:0] got_q [$];
    int          check_count = 0;
    int          error_count = 0;
    int          test_errors = 0;
    int          seed = 65;

    always #10 clk = ~clk;

    spi_sensor_link spi_sensor_link_inst (.*);

    spi_slave_model spi_slave_model_inst (.*);

    // responses are taken mid-cycle, clear of the clock edge.
    always @(negedge clk) begin
        if (reset_n && rsp_valid) begin
            got_q.push_back({rsp_slave, rsp_addr, rsp_rdata});
        end
    end

    task automatic check_hex(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    // Drives one request for a cycle and predicts its response from the shadow copy.
    task automatic drive_request(input slave_sel_t slave, input reg_addr_t addr,
                                 input logic write, input reg_data_t wdata, input bit kept);
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req_slave = slave;
        req_addr  = addr;
        req_write = write;
        req_wdata = wdata;
        if (kept && write) begin
            shadow[slave][addr] = wdata;
            exp_q.push_back({slave, addr, 8'h00});
        end else if (kept) begin
            exp_q.push_back({slave, addr, shadow[slave][addr]});
        end
    endtask

    task automatic release_request();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic collect_responses();
        int          waited;
        logic [15:0] got;
        logic [15:0] exp;
        while (exp_q.size() > 0) begin
            waited = 0;
            while ((got_q.size() == 0) && (waited < 200)) begin
                @(negedge clk);
                waited++;
            end
            if (got_q.size() == 0) begin
                $display("timeout: no response within 200 cycles, %0d still expected",
                         exp_q.size());
                error_count++;
                exp_q.delete();
                return;
            end
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            check_hex("rsp_slave", got[15], exp[15]);
            check_hex("rsp_addr", got[14:8], exp[14:8]);
            check_hex("rsp_rdata", got[7:0], exp[7:0]);
        end
    endtask

    task automatic test_done(input string name);
        if (got_q.size() != 0) begin
            $display("%s: %0d responses arrived that no request asked for", name, got_q.size());
            error_count++;
            got_q.delete();
        end
        $display("%s finished with %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_hex("ss_n", ss_n, 16'h3);
        check_hex("sclk", sclk, sclk_cpol);
        check_hex("mosi", mosi, 16'h0);
        check_hex("overflow", overflow, 16'h0);
        repeat (20) begin
            @(negedge clk);
            check_hex("rsp_valid", rsp_valid, 16'h0);
        end
        test_done("reset_state");
    endtask

    task automatic read_defaults();
        reg_addr_t addrs [4] = '{7'h00, 7'h15, 7'h4a, 7'h7f};
        for (int s = 0; s < num_slaves; s++) begin
            foreach (addrs[i]) begin
                drive_request(slave_sel_t'(s), addrs[i], 1'b0, 8'h00, 1'b1);
                release_request();
                collect_responses();
            end
        end
        test_done("default_reads");
    endtask

    task automatic write_then_read();
        drive_request(1'b1, 7'h22, 1'b1, 8'hc3, 1'b1);
        release_request();
        drive_request(1'b1, 7'h22, 1'b0, 8'h00, 1'b1);
        release_request();
        drive_request(1'b0, 7'h22, 1'b0, 8'h00, 1'b1); // slave 0 keeps its reset value.
        release_request();
        collect_responses();
        test_done("write_then_read");
    endtask

    task automatic queued_burst();
        drive_request(1'b0, 7'h10, 1'b1, 8'h9e, 1'b1);
        drive_request(1'b1, 7'h10, 1'b0, 8'h00, 1'b1);
        drive_request(1'b0, 7'h10, 1'b0, 8'h00, 1'b1);
        drive_request(1'b1, 7'h41, 1'b1, 8'h07, 1'b1);
        release_request();
        collect_responses();
        test_done("queued_burst");
    endtask

    // One request goes in flight and four wait in the queue, so the sixth is lost.
    task automatic overflow_drop();
        for (int i = 1; i <= 6; i++) begin
            drive_request(slave_sel_t'(i % 2), reg_addr_t'(i), 1'b0, 8'h00, i < 6);
        end
        release_request();
        collect_responses();
        check_hex("overflow", overflow, 16'h1);
        repeat (200) @(negedge clk);
        test_done("overflow");
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        repeat (40) begin
            r = $random(seed);
            drive_request(r[0], r[7:1], r[8], r[23:16], 1'b1);
            release_request();
            collect_responses();
        end
        test_done("random_traffic");
    endtask

    initial begin
        reset_n   = 1'b0;
        req_valid = 1'b0;
        req_slave = '0;
        req_addr  = '0;
        req_write = 1'b0;
        req_wdata = '0;
        for (int a = 0; a < 128; a++) begin
            shadow[0][a] = reg_data_t'(a) ^ 8'h5a;
            shadow[1][a] = reg_data_t'(a) + 8'h30;
        end
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        check_reset_state();
        read_defaults();
        write_then_read();
        queued_burst();
        overflow_drop();
        random_traffic();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: spi_sensor_link.f
logic/spi_link_pkg.sv
logic/spi_master.sv
logic/reg_access_sequencer.sv
logic/spi_sensor_link.sv
dv/spi_slave_model.sv
dv/tb_spi_sensor_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

build_dir=obj_dir
sim_bin=sim_spi_sensor_link
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spi_sensor_link \
    -f spi_sensor_link.f \
    -Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Something failed" "$log_file"; then
    exit 1
fi
exit 0
